//--- tb.f
+incdir+rtl
rtl/ahb_axi_pkg.sv
rtl/axi_chan_hold.sv
rtl/axi_wr_chan.sv
rtl/axi_rd_chan.sv
rtl/ahb_slave_ctrl.sv
rtl/ahb_to_axi4.sv
bench/axi_slave_model.sv
bench/tb_ahb_to_axi4.sv

//--- Bender.yml
package:
  name: ahb_to_axi4

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ahb_axi_pkg.sv
      - rtl/axi_chan_hold.sv
      - rtl/axi_wr_chan.sv
      - rtl/axi_rd_chan.sv
      - rtl/ahb_slave_ctrl.sv
      - rtl/ahb_to_axi4.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/axi_slave_model.sv
      - bench/tb_ahb_to_axi4.sv

//--- bench/tb_ahb_to_axi4.sv
`timescale 1ns/10ps
`include "ahb_axi_macros.svh"

module tb_ahb_to_axi4;

   localparam logic [31:0] err_base = 32'h0000_1000;
   localparam logic [15:0] seed     = 16'd15086;
   localparam int          xfer_tmo = 200;

   logic clk, rst_l;
   logic [31:0] haddr, hwdata, hrdata;
   logic [2:0]  hsize;
   logic [1:0]  htrans;
   logic [3:0]  hprot;
   logic        hwrite, hnonsec, hsel, hreadyin, hreadyout, hresp;
   logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;
   logic [0:0]  awid, arid;
   logic [31:0] awaddr, wdata, araddr, rdata;
   logic [7:0]  awlen, arlen;
   logic [2:0]  awsize, awprot, arsize, arprot;
   logic [1:0]  awburst, arburst, bresp, rresp;
   logic [3:0]  wstrb;

   int errors, checks, tests, aw_cnt, w_cnt, ar_cnt, valid_cycles;
   logic [31:0] aw_cap_addr, ar_cap_addr, w_cap_data;
   logic [2:0]  aw_cap_size, aw_cap_prot, ar_cap_size, ar_cap_prot;
   logic [3:0]  w_cap_strb;
   logic        w_cap_last;
   logic [7:0]  shadow [0:255];
   logic        known [0:255];
   logic [15:0] lfsr;

   ahb_to_axi4 UUT (.*);

   axi_slave_model #(.err_base(err_base), .seed(seed)) u_mem (
      .clk, .rst_l, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
      .rdata, .rresp
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ******************************
   // bus monitors and protocol checks
   // ******************************
   always @(posedge clk) begin
      if (awvalid | wvalid | arvalid) valid_cycles++;
      if (awvalid && awready) begin
         aw_cnt++;
         {aw_cap_addr, aw_cap_size, aw_cap_prot} = {awaddr, awsize, awprot};
      end
      if (wvalid && wready) begin
         w_cnt++;
         {w_cap_data, w_cap_strb, w_cap_last} = {wdata, wstrb, wlast};
      end
      if (arvalid && arready) begin
         ar_cnt++;
         {ar_cap_addr, ar_cap_size, ar_cap_prot} = {araddr, arsize, arprot};
      end
   end

   a_aw_stable: assert property (@(posedge clk) disable iff (rst_l)
      awvalid && !awready |=> awvalid && $stable({awaddr, awsize, awprot}))
      else begin
         errors++;
         $display("aw beat dropped or changed while stalled");
      end
   a_w_stable: assert property (@(posedge clk) disable iff (rst_l)
      wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
      else begin
         errors++;
         $display("w beat dropped or changed while stalled");
      end
   a_ar_stable: assert property (@(posedge clk) disable iff (rst_l)
      arvalid && !arready |=> arvalid && $stable({araddr, arsize, arprot}))
      else begin
         errors++;
         $display("ar beat dropped or changed while stalled");
      end
   a_single_beat: assert property (@(posedge clk) disable iff (rst_l)
      (awlen == 8'd0) && (arlen == 8'd0) && wlast)
      else begin
         errors++;
         $display("ERROR awlen %h arlen %h wlast %h", awlen, arlen, wlast);
      end

   // id zero and incr bursts on both address channels
   a_fixed_id_burst: assert property (@(posedge clk) disable iff (rst_l)
      (awid == 1'b0) && (arid == 1'b0) && (awburst == 2'b01) && (arburst == 2'b01))
      else begin
         errors++;
         $display("ERROR awid %h arid %h awburst %h arburst %h", awid, arid, awburst, arburst);
      end

   // the bridge is always waiting when the slave answers
   a_b_taken: assert property (@(posedge clk) disable iff (rst_l)
      bvalid |-> bready)
      else begin
         errors++;
         $display("write response offered while bready was low");
      end
   a_r_taken: assert property (@(posedge clk) disable iff (rst_l)
      rvalid |-> rready)
      else begin
         errors++;
         $display("read data offered while rready was low");
      end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   // lanes from the addressed byte up to the end of the transfer
   function automatic logic [3:0] lanes_of(input logic [31:0] addr, input logic [2:0] size);
      logic [3:0] s;
      for (int i = 0; i < 4; i++) begin
         s[i] = (i >= addr[1:0]) && (i < addr[1:0] + (1 << size));
      end
      return s;
   endfunction

   function automatic logic [2:0] prot_of(input logic [3:0] prot, input logic nsec);
      logic [2:0] p;
      p[0] = prot[1];    // privileged
      p[1] = nsec;
      p[2] = !prot[0];   // hprot flags data, axprot flags instruction
      return p;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
         else begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
         end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %s finished, errors so far %0d", name, errors);
   endtask

   // starts on a falling edge with hreadyout high, returns on the completing one
   task automatic ahb_xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data, input logic [3:0] prot, input logic nsec,
                           output logic [31:0] rd, output logic resp, output logic two_cyc);
      int   n;
      logic prev;
      {hsel, htrans, haddr, hsize, hwrite} = {1'b1, `HTRANS_NONSEQ, addr, size, wr};
      {hprot, hnonsec} = {prot, nsec};
      @(negedge clk);
      {hsel, htrans, hwdata} = {1'b0, `HTRANS_IDLE, data};
      n    = 0;
      prev = 1'b0;
      while (hreadyout !== 1'b1 && n < xfer_tmo) begin
         prev = hresp;
         @(negedge clk);
         n++;
      end
      if (hreadyout !== 1'b1) begin
         $display("transfer at address %h never completed", addr);
         $display("STATUS: FAIL");
         $finish;
      end
      rd      = hrdata;
      resp    = hresp;
      two_cyc = prev & hresp;
   endtask

   task automatic write_check(input logic [31:0] addr, input logic [2:0] size,
                              input logic [31:0] data, input logic [3:0] prot, input logic nsec);
      int          aw0, w0;
      logic [31:0] rd;
      logic        resp, two;
      logic [3:0]  s;
      aw0 = aw_cnt;
      w0  = w_cnt;
      s   = lanes_of(addr, size);
      ahb_xfer(1'b1, addr, size, data, prot, nsec, rd, resp, two);
      check_val("aw count", aw_cnt, aw0 + 1);
      check_val("w count", w_cnt, w0 + 1);
      check_val("awaddr", aw_cap_addr, addr);
      check_val("awsize", aw_cap_size, size);
      check_val("awprot", aw_cap_prot, prot_of(prot, nsec));
      check_val("wdata", w_cap_data, data);
      check_val("wstrb", w_cap_strb, s);
      check_val("wlast", w_cap_last, 1'b1);
      check_val("hresp", resp, 1'b0);
      for (int i = 0; i < 4; i++) begin
         if (s[i]) begin
            shadow[{addr[7:2], i[1:0]}] = data[8*i +: 8];
            known[{addr[7:2], i[1:0]}]  = 1'b1;
         end
      end
   endtask

   task automatic read_check(input logic [31:0] addr, input logic [2:0] size,
                             input logic [3:0] prot, input logic nsec);
      int          ar0;
      logic [31:0] rd;
      logic        resp, two;
      logic [3:0]  s;
      ar0 = ar_cnt;
      s   = lanes_of(addr, size);
      ahb_xfer(1'b0, addr, size, '0, prot, nsec, rd, resp, two);
      check_val("ar count", ar_cnt, ar0 + 1);
      check_val("araddr", ar_cap_addr, addr);
      check_val("arsize", ar_cap_size, size);
      check_val("arprot", ar_cap_prot, prot_of(prot, nsec));
      check_val("hresp", resp, 1'b0);
      for (int i = 0; i < 4; i++) begin
         if (s[i] && known[{addr[7:2], i[1:0]}]) begin
            check_val("hrdata byte", rd[8*i +: 8], shadow[{addr[7:2], i[1:0]}]);
         end
      end
   endtask

   task automatic err_check(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                            input logic on_axi);
      int          v0;
      logic [31:0] rd;
      logic        resp, two;
      v0 = valid_cycles;
      ahb_xfer(wr, addr, size, 32'hdead_beef, 4'b0011, 1'b0, rd, resp, two);
      check_val("hresp", resp, 1'b1);
      check_val("hresp before hreadyout", two, 1'b1);
      if (!on_axi) check_val("valid cycles", valid_cycles, v0);
   endtask

   // ******************************
   // test sequence
   // ******************************
   initial begin
      logic [31:0] r, a, d;
      logic [2:0]  sz;
      {errors, checks, tests, aw_cnt, w_cnt, ar_cnt, valid_cycles} = '0;
      lfsr  = seed;
      rst_l = 1'b1;
      {haddr, hwdata, hsize, htrans, hprot, hwrite, hnonsec, hsel} = '0;
      hreadyin = 1'b1;
      for (int i = 0; i < 256; i++) known[i] = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_l = 1'b0;
      @(negedge clk);

      check_val("hreadyout", hreadyout, 1'b1);
      check_val("hresp", hresp, 1'b0);
      check_val("valids", {awvalid, wvalid, arvalid}, 3'b000);
      check_val("bready rready", {bready, rready}, 2'b00);
      end_test("reset");

      write_check(32'h20, 3'd2, 32'h1122_3344, 4'b0011, 1'b0);
      write_check(32'h21, 3'd0, 32'haabb_ccdd, 4'b0000, 1'b1);
      write_check(32'h22, 3'd1, 32'h5566_7788, 4'b0010, 1'b0);
      write_check(32'h24, 3'd2, 32'hcafe_f00d, 4'b0001, 1'b1);
      end_test("aligned writes");

      read_check(32'h20, 3'd2, 4'b0011, 1'b0);
      read_check(32'h23, 3'd0, 4'b0001, 1'b0);
      read_check(32'h26, 3'd1, 4'b0010, 1'b1);
      end_test("reads");

      err_check(1'b1, 32'h31, 3'd1, 1'b0);
      err_check(1'b0, 32'h32, 3'd2, 1'b0);
      end_test("misaligned");

      err_check(1'b1, err_base + 32'h8, 3'd2, 1'b1);
      err_check(1'b0, err_base + 32'h4, 3'd2, 1'b1);
      end_test("error region");

      for (int k = 0; k < 16; k++) begin
         take_bits(32, d);
         write_check(32'h40 + 4 * k, 3'd2, d, 4'b0011, 1'b0);
      end
      for (int k = 0; k < 40; k++) begin
         take_bits(2, r);
         sz = (r[1:0] == 2'd3) ? 3'd2 : r[2:0];
         take_bits(6, a);
         a = 32'h40 + (a & ~((32'd1 << sz) - 1));
         take_bits(32, d);
         take_bits(1, r);
         if (r[0]) write_check(a, sz, d, d[3:0], d[4]);
         else read_check(a, sz, d[3:0], d[4]);
      end
      end_test("random back-pressure");

      $display("tests %0d checks %0d errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- bench/axi_slave_model.sv
`timescale 1ns/10ps
`include "ahb_axi_macros.svh"

module axi_slave_model #(
   parameter logic [`AXI_ADDR_W-1:0] err_base = 32'h0000_1000,
   parameter logic [15:0]            seed     = 16'd15086
) (
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [`AXI_ADDR_W-1:0] awaddr,
   input  logic                   wvalid,
   output logic                   wready,
   input  logic [`AXI_DATA_W-1:0] wdata,
   input  logic [`AXI_STRB_W-1:0] wstrb,
   output logic                   bvalid,
   input  logic                   bready,
   output logic [1:0]             bresp,
   input  logic                   arvalid,
   output logic                   arready,
   input  logic [`AXI_ADDR_W-1:0] araddr,
   output logic                   rvalid,
   input  logic                   rready,
   output logic [`AXI_DATA_W-1:0] rdata,
   output logic [1:0]             rresp
);

   logic [`AXI_DATA_W-1:0] mem [0:63];
   logic [15:0]            lfsr;
   logic                   rst_q;
   logic                   aw_fire, w_fire, b_fire, ar_fire, r_fire;
   logic                   have_aw, have_w;
   logic [`AXI_ADDR_W-1:0] aw_a, ar_a;
   logic [`AXI_DATA_W-1:0] w_d;
   logic [`AXI_STRB_W-1:0] w_s;

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   initial begin
      {awready, wready, arready, bvalid, rvalid} = '0;
      bresp = 2'b00;
      rresp = 2'b00;
      rdata = '0;
      lfsr  = seed;
      for (int i = 0; i < 64; i++) begin
         mem[i] = {8'hc3 ^ i[7:0], i[7:0], ~i[7:0], 8'h3c + i[7:0]};
      end
   end

   // ******************************
   // handshakes seen on the rising edge
   // ******************************
   always @(posedge clk) begin
      rst_q   <= rst_l;   // reset as seen by the falling edge logic
      aw_fire <= awvalid & awready;
      w_fire  <= wvalid & wready;
      b_fire  <= bvalid & bready;
      ar_fire <= arvalid & arready;
      r_fire  <= rvalid & rready;
      if (awvalid & awready) aw_a <= awaddr;
      if (arvalid & arready) ar_a <= araddr;
      if (wvalid & wready) begin
         w_d <= wdata;
         w_s <= wstrb;
      end
   end

   // responses and readiness change on the falling edge
   always @(negedge clk) begin
      if (rst_q) begin
         {awready, wready, arready, bvalid, rvalid} = '0;
         {have_aw, have_w} = '0;
         bresp = 2'b00;
         rresp = 2'b00;
         rdata = '0;
         lfsr  = seed;
      end else begin
         lfsr    = lfsr_next(lfsr);
         awready = lfsr[0];
         lfsr    = lfsr_next(lfsr);
         wready  = lfsr[0];
         lfsr    = lfsr_next(lfsr);
         arready = lfsr[0];
         if (b_fire) bvalid = 1'b0;
         if (r_fire) rvalid = 1'b0;
         if (aw_fire) have_aw = 1'b1;
         if (w_fire) have_w = 1'b1;
         if (have_aw && have_w) begin
            {have_aw, have_w} = '0;
            bresp  = (aw_a >= err_base) ? 2'b10 : `AXI_RESP_OKAY;   // slverr
            bvalid = 1'b1;
            for (int i = 0; i < `AXI_STRB_W; i++) begin
               if (w_s[i] && aw_a < err_base) mem[aw_a[7:2]][8*i +: 8] = w_d[8*i +: 8];
            end
         end
         if (ar_fire) begin
            rvalid = 1'b1;
            rresp  = (ar_a >= err_base) ? 2'b10 : `AXI_RESP_OKAY;
            rdata  = (ar_a >= err_base) ? '0 : mem[ar_a[7:2]];
         end
      end
   end

endmodule

//--- rtl/ahb_to_axi4.sv
`timescale 1ns/10ps
`include "ahb_axi_macros.svh"

module ahb_to_axi4 import ahb_axi_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_l,
   // ahb-lite slave
   input  logic [`AXI_ADDR_W-1:0] haddr,
   input  logic [2:0]             hsize,
   input  logic [1:0]             htrans,
   input  logic                   hwrite,
   input  logic [`AXI_DATA_W-1:0] hwdata,
   input  logic [3:0]             hprot,
   input  logic                   hnonsec,
   input  logic                   hsel,
   input  logic                   hreadyin,
   output logic [`AXI_DATA_W-1:0] hrdata,
   output logic                   hreadyout,
   output logic                   hresp,
   // axi4 write channels
   output logic                   awvalid,
   input  logic                   awready,
   output logic [`AXI_ID_W-1:0]   awid,
   output logic [`AXI_ADDR_W-1:0] awaddr,
   output logic [7:0]             awlen,
   output logic [2:0]             awsize,
   output logic [1:0]             awburst,
   output logic [2:0]             awprot,
   output logic                   wvalid,
   input  logic                   wready,
   output logic [`AXI_DATA_W-1:0] wdata,
   output logic [`AXI_STRB_W-1:0] wstrb,
   output logic                   wlast,
   input  logic                   bvalid,
   output logic                   bready,
   input  logic [1:0]             bresp,
   // axi4 read channels
   output logic                   arvalid,
   input  logic                   arready,
   output logic [`AXI_ID_W-1:0]   arid,
   output logic [`AXI_ADDR_W-1:0] araddr,
   output logic [7:0]             arlen,
   output logic [2:0]             arsize,
   output logic [1:0]             arburst,
   output logic [2:0]             arprot,
   input  logic                   rvalid,
   output logic                   rready,
   input  logic [`AXI_DATA_W-1:0] rdata,
   input  logic [1:0]             rresp
);

   logic     wr_req;
   logic     rd_req;
   axi_ax_t  req_ax;
   axi_w_t   req_w;
   ahb_rsp_t wr_rsp;
   ahb_rsp_t rd_rsp;
   axi_ax_t  aw_s;
   axi_w_t   w_s;
   axi_ax_t  ar_s;

   ahb_slave_ctrl u_ctrl (
      .clk, .rst_l, .haddr, .hsize, .htrans, .hwrite, .hwdata, .hprot, .hnonsec,
      .hsel, .hreadyin, .hrdata, .hreadyout, .hresp,
      .wr_req, .rd_req, .ax(req_ax), .w(req_w), .wr_rsp, .rd_rsp
   );

   axi_wr_chan u_wr (
      .clk, .rst_l, .wr_req, .ax(req_ax), .w(req_w),
      .awvalid, .awready, .aw(aw_s), .wvalid, .wready, .w_out(w_s),
      .bvalid, .bready, .bresp, .rsp(wr_rsp)
   );

   axi_rd_chan u_rd (
      .clk, .rst_l, .rd_req, .ax(req_ax),
      .arvalid, .arready, .ar(ar_s), .rvalid, .rready, .rdata, .rresp, .rsp(rd_rsp)
   );

   // ******************************
   // single beat, fixed id
   // ******************************
   assign awid    = '0;
   assign awaddr  = aw_s.addr;
   assign awlen   = 8'd0;
   assign awsize  = aw_s.size;
   assign awburst = `AXI_BURST_INCR;
   assign awprot  = aw_s.prot;
   assign wdata   = w_s.data;
   assign wstrb   = w_s.strb;
   assign wlast   = 1'b1;        // every write is one beat
   assign arid    = '0;
   assign araddr  = ar_s.addr;
   assign arlen   = 8'd0;
   assign arsize  = ar_s.size;
   assign arburst = `AXI_BURST_INCR;
   assign arprot  = ar_s.prot;

endmodule

//--- rtl/ahb_slave_ctrl.sv
`timescale 1ns/10ps
`include "ahb_axi_macros.svh"

module ahb_slave_ctrl import ahb_axi_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic [`AXI_ADDR_W-1:0] haddr,
   input  logic [2:0]             hsize,
   input  logic [1:0]             htrans,
   input  logic                   hwrite,
   input  logic [`AXI_DATA_W-1:0] hwdata,
   input  logic [3:0]             hprot,
   input  logic                   hnonsec,
   input  logic                   hsel,
   input  logic                   hreadyin,
   output logic [`AXI_DATA_W-1:0] hrdata,
   output logic                   hreadyout,
   output logic                   hresp,
   output logic                   wr_req,
   output logic                   rd_req,
   output axi_ax_t                ax,
   output axi_w_t                 w,
   input  ahb_rsp_t               wr_rsp,
   input  ahb_rsp_t               rd_rsp
);

   localparam int LANE_W = $clog2(`AXI_STRB_W);

   typedef enum logic [2:0] {
      s_idle,
      s_issue,    // data phase, hwdata valid here
      s_wait,     // axi side busy
      s_err1,
      s_err2
   } state_t;

   state_t                 state;
   state_t                 nxt_state;
   logic                   accept;
   logic                   misalign;
   logic                   chan_done;
   logic                   chan_err;
   logic                   write_q;
   axi_ax_t                ax_q;
   logic [`AXI_ADDR_W-1:0] size_mask;
   logic [`AXI_STRB_W-1:0] run;
   logic [`AXI_STRB_W-1:0] strb;

   // ******************************
   // address phase
   // ******************************
   assign accept = hsel & hreadyin & hreadyout &
                   ((htrans == `HTRANS_NONSEQ) | (htrans == `HTRANS_SEQ));

   always_ff @(posedge clk) begin
      if (accept) begin
         ax_q.addr <= haddr;
         ax_q.size <= hsize;
         ax_q.prot <= {~hprot[0], hnonsec, hprot[1]};   // instr, nonsecure, privileged
         write_q   <= hwrite;
      end
   end

   // low address bits below the transfer size must be zero
   assign size_mask = ({{(`AXI_ADDR_W-1){1'b0}}, 1'b1} << ax_q.size) - 1'b1;
   assign misalign  = |(ax_q.addr & size_mask);

   // run of 2**size lanes, moved up to the addressed byte
   always_comb begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
         run[i] = (i < (1 << ax_q.size));
      end
      strb = run << ax_q.addr[LANE_W-1:0];
   end

   // ******************************
   // request to the channel parts
   // ******************************
   assign wr_req = (state == s_issue) & write_q & ~misalign;
   assign rd_req = (state == s_issue) & ~write_q & ~misalign;
   assign ax     = ax_q;
   assign w      = '{data: hwdata, strb: strb};

   assign chan_done = wr_rsp.done | rd_rsp.done;
   assign chan_err  = (wr_rsp.done & wr_rsp.err) | (rd_rsp.done & rd_rsp.err);
   assign hrdata    = rd_rsp.rdata;

   // ******************************
   // ahb response and fsm
   // ******************************
   always_comb begin
      hreadyout = 1'b0;
      hresp     = 1'b0;
      case (state)
         s_idle:  hreadyout = 1'b1;
         s_wait:  hreadyout = chan_done & ~chan_err;   // ends in the done cycle
         s_err1:  hresp     = 1'b1;
         s_err2: begin
            hresp     = 1'b1;
            hreadyout = 1'b1;
         end
         default: hreadyout = 1'b0;
      endcase
   end

   always_comb begin
      nxt_state = state;
      if (accept) begin
         nxt_state = s_issue;      // back to back transfer
      end else begin
         case (state)
            s_idle:  nxt_state = s_idle;
            s_issue: nxt_state = misalign ? s_err1 : s_wait;
            s_wait: begin
               if (chan_done) begin
                  nxt_state = chan_err ? s_err1 : s_idle;
               end
            end
            s_err1:  nxt_state = s_err2;
            s_err2:  nxt_state = s_idle;
            default: nxt_state = s_idle;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         state <= s_idle;
      end else begin
         state <= nxt_state;
      end
   end

   a_idle_no_err: assert property (@(posedge clk) disable iff (rst_l)
      state == s_idle |-> !hresp);

endmodule

//--- rtl/axi_rd_chan.sv
`timescale 1ns/10ps
`include "ahb_axi_macros.svh"

module axi_rd_chan import ahb_axi_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_l,
   input  logic                   rd_req,
   input  axi_ax_t                ax,
   output logic                   arvalid,
   input  logic                   arready,
   output axi_ax_t                ar,
   input  logic                   rvalid,
   output logic                   rready,
   input  logic [`AXI_DATA_W-1:0] rdata,
   input  logic [1:0]             rresp,
   output ahb_rsp_t               rsp
);

   logic                   waiting;
   logic                   r_hs;
   logic                   done_q;
   logic                   err_q;
   logic [`AXI_DATA_W-1:0] rdata_q;

   axi_chan_hold #(.payload_t(axi_ax_t)) u_ar_hold (
      .clk     (clk),
      .rst_l   (rst_l),
      .load    (rd_req),
      .data_in (ax),
      .valid   (arvalid),
      .ready   (arready),
      .data    (ar)
   );

   assign r_hs   = rvalid & rready;
   assign rready = waiting;   // always room, ahb blocks until data returns

   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         waiting <= 1'b0;
         done_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         if (rd_req) begin
            waiting <= 1'b1;
         end else if (r_hs) begin
            waiting <= 1'b0;
         end
         done_q <= r_hs;
         err_q  <= r_hs & (rresp != `AXI_RESP_OKAY);
      end
   end

   // read data stays put until the next read returns
   always_ff @(posedge clk) begin
      if (r_hs) begin
         rdata_q <= rdata;
      end
   end

   assign rsp = '{done: done_q, err: err_q, rdata: rdata_q};

endmodule

//--- rtl/axi_wr_chan.sv
`timescale 1ns/10ps
`include "ahb_axi_macros.svh"

module axi_wr_chan import ahb_axi_pkg::*; (
   input  logic       clk,
   input  logic       rst_l,
   input  logic       wr_req,
   input  axi_ax_t    ax,
   input  axi_w_t     w,
   output logic       awvalid,
   input  logic       awready,
   output axi_ax_t    aw,
   output logic       wvalid,
   input  logic       wready,
   output axi_w_t     w_out,
   input  logic       bvalid,
   output logic       bready,
   input  logic [1:0] bresp,
   output ahb_rsp_t   rsp
);

   logic waiting;
   logic b_hs;
   logic done_q;
   logic err_q;

   // aw and w each complete on their own
   axi_chan_hold #(.payload_t(axi_ax_t)) u_aw_hold (
      .clk     (clk),
      .rst_l   (rst_l),
      .load    (wr_req),
      .data_in (ax),
      .valid   (awvalid),
      .ready   (awready),
      .data    (aw)
   );

   axi_chan_hold #(.payload_t(axi_w_t)) u_w_hold (
      .clk     (clk),
      .rst_l   (rst_l),
      .load    (wr_req),
      .data_in (w),
      .valid   (wvalid),
      .ready   (wready),
      .data    (w_out)
   );

   assign b_hs   = bvalid & bready;
   assign bready = waiting;

   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         waiting <= 1'b0;
         done_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         if (wr_req) begin
            waiting <= 1'b1;
         end else if (b_hs) begin
            waiting <= 1'b0;
         end
         done_q <= b_hs;                                  // one cycle after b
         err_q  <= b_hs & (bresp != `AXI_RESP_OKAY);      // slverr or decerr
      end
   end

   assign rsp = '{done: done_q, err: err_q, rdata: '0};

   // slave must not answer a write that was never issued
   a_b_when_busy: assert property (@(posedge clk) disable iff (rst_l)
      bvalid |-> waiting);

endmodule

//--- rtl/axi_chan_hold.sv
`timescale 1ns/10ps

module axi_chan_hold import ahb_axi_pkg::*; #(
   parameter type payload_t = axi_ax_t
) (
   input  logic     clk,
   input  logic     rst_l,
   input  logic     load,
   input  payload_t data_in,
   output logic     valid,
   input  logic     ready,
   output payload_t data
);

   logic handshake;

   assign handshake = valid & ready;

   // valid goes up the cycle after load, drops the cycle after the handshake
   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         valid <= 1'b0;
      end else if (load) begin
         valid <= 1'b1;
      end else if (handshake) begin
         valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         data <= data_in;   // held until the slave takes it
      end
   end

   // ******************************
   // protocol checks
   // ******************************

   // stalled beat keeps its payload and its valid
   a_hold_stable: assert property (@(posedge clk) disable iff (rst_l)
      valid && !ready |=> valid && $stable(data));

   // requester must not reload a beat that is still pending
   a_no_overrun: assert property (@(posedge clk) disable iff (rst_l)
      load |-> !valid);

endmodule

//--- rtl/ahb_axi_pkg.sv
`include "ahb_axi_macros.svh"

package ahb_axi_pkg;

   // ******************************
   // channel payloads
   // ******************************

   // address beat, shared by aw and ar
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [2:0]             size;   // log2 of bytes in the beat
      logic [2:0]             prot;
   } axi_ax_t;

   // single write beat
   typedef struct packed {
      logic [`AXI_DATA_W-1:0] data;
      logic [`AXI_STRB_W-1:0] strb;
   } axi_w_t;

   // ******************************
   // channel result back to ahb side
   // ******************************

   // done is a one cycle pulse, err only means something with done
   typedef struct packed {
      logic                   done;
      logic                   err;
      logic [`AXI_DATA_W-1:0] rdata;   // zero on the write side
   } ahb_rsp_t;

endpackage

//--- rtl/ahb_axi_macros.svh
`ifndef AHB_AXI_MACROS_SVH
`define AHB_AXI_MACROS_SVH

// ******************************
// bus widths
// ******************************
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W/8)      // one strobe per byte lane
`define AXI_ID_W   1

// ******************************
// ahb transfer types
// ******************************
`define HTRANS_IDLE   2'b00
`define HTRANS_BUSY   2'b01
`define HTRANS_NONSEQ 2'b10
`define HTRANS_SEQ    2'b11

// ******************************
// axi constants
// ******************************
`define AXI_RESP_OKAY  2'b00
`define AXI_BURST_INCR 2'b01             // single beats only, len is always 0

`endif
